//--- source/dcache_pkg.sv
// geometry is fixed at 16 sets of 2 ways with 64-bit lines and the width localparams must be kept in step by hand
`default_nettype none

package dcache_pkg;

	// ======================================================================
	// cache geometry
	// ======================================================================

	localparam int ADDR_W     = 32;
	localparam int LINE_BYTES = 8;
	localparam int LINE_W     = LINE_BYTES * 8;
	localparam int OFFSET_W   = 3;
	localparam int SETS       = 16;
	localparam int INDEX_W    = 4;
	localparam int WAYS       = 2;
	localparam int WAY_W      = 1;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

	// any nonzero start value keeps the victim LFSR out of its lock-up state
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [WAY_W-1:0]      way_t;
	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [LINE_BYTES-1:0] sel_t;

	// ======================================================================
	// bundles passed between the ports and the three internal blocks
	// ======================================================================

	// one CPU access always covers a whole line and sel picks the bytes to write
	typedef struct packed {
		logic  we;
		logic  nc;
		addr_t adr;
		sel_t  sel;
		line_t dat;
	} cpu_cmd_t;

	// memory transfers are whole lines so adr has its offset bits at zero
	typedef struct packed {
		logic  we;
		addr_t adr;
		line_t dat;
	} mem_cmd_t;

	// the latched request, already split so later stages never slice addresses
	typedef struct packed {
		tag_t   tag;
		index_t index;
		logic   we;
		logic   nc;
		sel_t   sel;
		line_t  dat;
	} req_fields_t;

	// what the ways report for the latched request
	typedef struct packed {
		logic  hit;
		way_t  hit_way;
		line_t hit_data;
		way_t  victim_way;
		logic  victim_dirty;
		tag_t  victim_tag;
		line_t victim_data;
	} lookup_t;

	// one line write into the ways, which also sets the valid bit
	typedef struct packed {
		logic   en;
		way_t   way;
		index_t index;
		tag_t   tag;
		line_t  data;
		logic   dirty;
	} array_wr_t;

	typedef enum logic [3:0] {
		IDLE, LOOKUP, DECIDE, WB_REQ, WB_DROP, FILL_REQ, FILL_DROP,
		UPDATE, NC_REQ, NC_DROP, RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- source/dcache_req_decode.sv
// accepts one CPU request at a time and holds it until done_i, so the CPU must keep req high until ack
`timescale 1ns/1ns
`default_nettype none

module dcache_req_decode
	import dcache_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire           cpu_req_i,
	input  wire cpu_cmd_t cpu_cmd_i,
	input  wire           done_i,
	output req_fields_t   fields_o,
	output logic          start_o
);

	// ======================================================================
	// request acceptance
	// ======================================================================

	// high from the accepting edge until the controller reports done
	logic busy_q;
	logic accept;

	// a request is taken only while nothing is in flight
	assign accept = cpu_req_i && !busy_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q  <= 1'b0;
			start_o <= 1'b0;
		end else begin
			// start is high for exactly the cycle after the latching edge
			start_o <= accept;
			if (accept) begin
				busy_q <= 1'b1;
			end else if (done_i) begin
				busy_q <= 1'b0;
			end
		end
	end

	// ======================================================================
	// command register and address split
	// ======================================================================

	// the fields stay frozen for the whole access because accept is masked by busy
	always_ff @(posedge clk) begin
		if (accept) begin
			fields_o.tag   <= cpu_cmd_i.adr[ADDR_W-1 -: TAG_W];
			fields_o.index <= cpu_cmd_i.adr[OFFSET_W +: INDEX_W];
			// the byte offset is dropped since every access moves a whole line
			fields_o.we    <= cpu_cmd_i.we;
			fields_o.nc    <= cpu_cmd_i.nc;
			fields_o.sel   <= cpu_cmd_i.sel;
			fields_o.dat   <= cpu_cmd_i.dat;
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_ways.sv
// snoop and invalidate-all drop modified lines without write-back and must not hit the set under lookup
`timescale 1ns/1ns
`default_nettype none

module dcache_ways
	import dcache_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire req_fields_t fields_i,
	input  wire              start_i,
	input  wire array_wr_t   wr_i,
	input  wire              snoop_v_i,
	input  wire addr_t       snoop_adr_i,
	input  wire              inv_all_i,
	output lookup_t          lookup_o
);

	// ======================================================================
	// storage
	// ======================================================================

	// tag and data memories per way
	tag_t  tag_mem  [WAYS][SETS];
	line_t data_mem [WAYS][SETS];

	// valid and modified bits per way, one bit per set
	logic [SETS-1:0] valid_q [WAYS];
	logic [SETS-1:0] dirty_q [WAYS];

	// synchronous read stage, loaded on start at the request index
	tag_t            rd_tag  [WAYS];
	line_t           rd_data [WAYS];
	logic [WAYS-1:0] rd_valid;
	logic [WAYS-1:0] rd_dirty;

	logic [15:0]     lfsr_q;
	index_t          snoop_index;
	tag_t            snoop_tag;
	logic [WAYS-1:0] snoop_match;
	logic            hit;
	way_t            hit_way;
	way_t            victim_way;
	lookup_t         lookup_d;

	// line writes from the controller, tags and data land together
	always_ff @(posedge clk) begin
		if (wr_i.en) begin
			tag_mem[wr_i.way][wr_i.index]  <= wr_i.tag;
			data_mem[wr_i.way][wr_i.index] <= wr_i.data;
		end
	end

	// the arrays are read once per request and then held for the compare
	always_ff @(posedge clk) begin
		if (start_i) begin
			for (int w = 0; w < WAYS; w++) begin
				rd_tag[w]  <= tag_mem[w][fields_i.index];
				rd_data[w] <= data_mem[w][fields_i.index];
			end
		end
	end

	// ======================================================================
	// snoop tag port
	// ======================================================================

	// a second read of the tag memory at the snoop index
	// so a snoop never competes with the request lookup
	assign snoop_index = snoop_adr_i[OFFSET_W +: INDEX_W];
	assign snoop_tag   = snoop_adr_i[ADDR_W-1 -: TAG_W];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			snoop_match[w] = snoop_v_i && valid_q[w][snoop_index]
				&& (tag_mem[w][snoop_index] == snoop_tag);
		end
	end

	// state bits, where later statements win when they touch the same bit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			rd_valid <= '0;
			rd_dirty <= '0;
		end else begin
			if (start_i) begin
				for (int w = 0; w < WAYS; w++) begin
					rd_valid[w] <= valid_q[w][fields_i.index];
					rd_dirty[w] <= dirty_q[w][fields_i.index];
				end
			end
			// every controller write leaves a valid line behind
			if (wr_i.en) begin
				valid_q[wr_i.way][wr_i.index] <= 1'b1;
				dirty_q[wr_i.way][wr_i.index] <= wr_i.dirty;
			end
			for (int w = 0; w < WAYS; w++) begin
				if (snoop_match[w]) begin
					valid_q[w][snoop_index] <= 1'b0;
				end
			end
			// modified bits are left alone because victim_dirty is gated by valid
			if (inv_all_i) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[w] <= '0;
				end
			end
		end
	end

	// ======================================================================
	// victim LFSR and compare
	// ======================================================================

	// taps 16, 14, 13 and 11 give a maximal length sequence
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr_q <= LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
		end
	end

	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (rd_valid[w] && (rd_tag[w] == fields_i.tag)) begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
		// the LFSR only decides when every way is valid
		// and the downward loop leaves the lowest free way selected
		victim_way = way_t'(lfsr_q[WAY_W-1:0]);
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!rd_valid[w]) begin
				victim_way = way_t'(w);
			end
		end
	end

	always_comb begin
		lookup_d.hit          = hit;
		lookup_d.hit_way      = hit_way;
		lookup_d.hit_data     = rd_data[hit_way];
		lookup_d.victim_way   = victim_way;
		lookup_d.victim_dirty = rd_valid[victim_way] && rd_dirty[victim_way];
		lookup_d.victim_tag   = rd_tag[victim_way];
		lookup_d.victim_data  = rd_data[victim_way];
	end

	// registered compare, valid two cycles after start
	always_ff @(posedge clk) begin
		lookup_o <= lookup_d;
	end

endmodule

`default_nettype wire

//--- source/dcache_resp_ctrl.sv
// non-cacheable writes store the whole line in memory and byte selects act only on cached lines
`timescale 1ns/1ns
`default_nettype none

module dcache_resp_ctrl
	import dcache_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire req_fields_t fields_i,
	input  wire              start_i,
	input  wire lookup_t     lookup_i,
	output array_wr_t        wr_o,
	output logic             done_o,
	input  wire              cpu_req_i,
	output logic             cpu_ack_o,
	output line_t            cpu_rdata_o,
	output logic             mem_req_o,
	input  wire              mem_ack_i,
	input  wire line_t       mem_rdata_i,
	output mem_cmd_t         mem_cmd_o
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	// lookup result frozen in DECIDE since the victim LFSR keeps moving
	lookup_t     lk_q;
	// line returned by memory on a fill or a non-cacheable read
	line_t       line_q;
	line_t       base_line;
	line_t       merged_line;
	addr_t       req_line_adr;
	mem_cmd_t    fill_cmd;
	mem_cmd_t    cmd_d;
	line_t       resp_d;
	logic        mem_req_d;
	logic        cpu_ack_d;
	logic        load_cmd;
	logic        load_line;
	logic        load_resp;

	assign req_line_adr = {fields_i.tag, fields_i.index, {OFFSET_W{1'b0}}};

	always_comb begin
		fill_cmd     = '0;
		fill_cmd.adr = req_line_adr;
	end

	// ======================================================================
	// line merge and array write
	// ======================================================================

	// a hit starts from the stored line and a miss from the fill data
	always_comb begin
		base_line   = lk_q.hit ? lk_q.hit_data : line_q;
		merged_line = base_line;
		if (fields_i.we) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (fields_i.sel[b]) begin
					merged_line[b*8 +: 8] = fields_i.dat[b*8 +: 8];
				end
			end
		end
	end

	// read hits leave the arrays untouched and keep their modified bit
	always_comb begin
		wr_o.en    = (state_q == UPDATE) && (fields_i.we || !lk_q.hit);
		wr_o.way   = lk_q.hit ? lk_q.hit_way : lk_q.victim_way;
		wr_o.index = fields_i.index;
		wr_o.tag   = fields_i.tag;
		wr_o.data  = merged_line;
		wr_o.dirty = fields_i.we;
	end

	// the decode block frees up on the same edge that drops ack
	assign done_o = (state_q == RESPOND) && !cpu_req_i;

	// ======================================================================
	// state machine
	// ======================================================================

	always_comb begin
		state_d   = state_q;
		mem_req_d = mem_req_o;
		cpu_ack_d = cpu_ack_o;
		load_cmd  = 1'b0;
		cmd_d     = fill_cmd;
		load_line = 1'b0;
		load_resp = 1'b0;
		resp_d    = line_q;
		case (state_q)
			IDLE: begin
				// non-cacheable requests skip the arrays entirely
				if (start_i && fields_i.nc) begin
					state_d   = NC_REQ;
					mem_req_d = 1'b1;
					load_cmd  = 1'b1;
					cmd_d     = '{we: fields_i.we, adr: req_line_adr, dat: fields_i.dat};
				end else if (start_i) begin
					state_d = LOOKUP;
				end
			end
			LOOKUP: begin
				state_d = DECIDE;
			end
			DECIDE: begin
				if (lookup_i.hit) begin
					state_d = UPDATE;
				end else if (lookup_i.victim_dirty) begin
					// the modified victim goes out before its slot is refilled
					state_d   = WB_REQ;
					mem_req_d = 1'b1;
					load_cmd  = 1'b1;
					cmd_d.we  = 1'b1;
					cmd_d.adr = {lookup_i.victim_tag, fields_i.index, {OFFSET_W{1'b0}}};
					cmd_d.dat = lookup_i.victim_data;
				end else begin
					state_d   = FILL_REQ;
					mem_req_d = 1'b1;
					load_cmd  = 1'b1;
				end
			end
			WB_REQ: begin
				if (mem_ack_i) begin
					state_d   = WB_DROP;
					mem_req_d = 1'b0;
				end
			end
			WB_DROP: begin
				// a new memory request waits for the old ack to fall
				if (!mem_ack_i) begin
					state_d   = FILL_REQ;
					mem_req_d = 1'b1;
					load_cmd  = 1'b1;
				end
			end
			FILL_REQ: begin
				if (mem_ack_i) begin
					state_d   = FILL_DROP;
					mem_req_d = 1'b0;
					load_line = 1'b1;
				end
			end
			FILL_DROP: begin
				if (!mem_ack_i) begin
					state_d = UPDATE;
				end
			end
			UPDATE: begin
				state_d   = RESPOND;
				cpu_ack_d = 1'b1;
				load_resp = 1'b1;
				resp_d    = merged_line;
			end
			NC_REQ: begin
				if (mem_ack_i) begin
					state_d   = NC_DROP;
					mem_req_d = 1'b0;
					load_line = 1'b1;
				end
			end
			NC_DROP: begin
				if (!mem_ack_i) begin
					state_d   = RESPOND;
					cpu_ack_d = 1'b1;
					load_resp = 1'b1;
				end
			end
			RESPOND: begin
				if (!cpu_req_i) begin
					state_d   = IDLE;
					cpu_ack_d = 1'b0;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q   <= IDLE;
			mem_req_o <= 1'b0;
			cpu_ack_o <= 1'b0;
		end else begin
			state_q   <= state_d;
			mem_req_o <= mem_req_d;
			cpu_ack_o <= cpu_ack_d;
		end
	end

	// mem_cmd_o only changes while mem_req_o is low, keeping it stable under req
	always_ff @(posedge clk) begin
		if (state_q == DECIDE) begin
			lk_q <= lookup_i;
		end
		if (load_cmd) begin
			mem_cmd_o <= cmd_d;
		end
		if (load_line) begin
			line_q <= mem_rdata_i;
		end
		if (load_resp) begin
			cpu_rdata_o <= resp_d;
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_top.sv
// one CPU request in flight, whole-line memory transfers, and snoops only while the cache is idle
`timescale 1ns/1ns
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	// CPU port with four-phase req/ack
	input  wire           cpu_req_i,
	input  wire cpu_cmd_t cpu_cmd_i,
	output logic          cpu_ack_o,
	output line_t         cpu_rdata_o,
	// memory port with four-phase req/ack
	output logic          mem_req_o,
	output mem_cmd_t      mem_cmd_o,
	input  wire           mem_ack_i,
	input  wire line_t    mem_rdata_i,
	// single-cycle invalidation pulses
	input  wire           snoop_v_i,
	input  wire addr_t    snoop_adr_i,
	input  wire           inv_all_i
);

	req_fields_t fields;
	logic        start;
	logic        done;
	lookup_t     lookup;
	array_wr_t   array_wr;

	// latches the request and splits the address
	dcache_req_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.cpu_req_i (cpu_req_i),
		.cpu_cmd_i (cpu_cmd_i),
		.done_i    (done),
		.fields_o  (fields),
		.start_o   (start)
	);

	// tag and data arrays with hit compare and victim choice
	dcache_ways u_ways (
		.clk         (clk),
		.rst         (rst),
		.fields_i    (fields),
		.start_i     (start),
		.wr_i        (array_wr),
		.snoop_v_i   (snoop_v_i),
		.snoop_adr_i (snoop_adr_i),
		.inv_all_i   (inv_all_i),
		.lookup_o    (lookup)
	);

	// miss handling and both handshakes
	dcache_resp_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.fields_i    (fields),
		.start_i     (start),
		.lookup_i    (lookup),
		.wr_o        (array_wr),
		.done_o      (done),
		.cpu_req_i   (cpu_req_i),
		.cpu_ack_o   (cpu_ack_o),
		.cpu_rdata_o (cpu_rdata_o),
		.mem_req_o   (mem_req_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i),
		.mem_cmd_o   (mem_cmd_o)
	);

endmodule

`default_nettype wire

//--- tb/dcache_checker.sv
// bound into dcache_top, watches the CPU ack rule, memory req hold and command stability, and reset values
`timescale 1ns/1ns
`default_nettype none

module dcache_checker
	import dcache_pkg::*;
(
	input wire           clk,
	input wire           rst,
	input wire           cpu_req_i,
	input wire           cpu_ack_i,
	input wire           mem_req_i,
	input wire           mem_ack_i,
	input wire mem_cmd_t mem_cmd_i,
	input wire           wr_en_i
);

	// number of assertion failures seen so far
	int failures = 0;

	// ======================================================================
	// four-phase handshake order
	// ======================================================================

	// the cache may only answer a CPU request that is actually raised
	assert property (@(posedge clk) disable iff (rst) $rose(cpu_ack_i) |-> cpu_req_i)
		else begin
			$error("cpu_ack_o rose while cpu_req_i was low");
			failures++;
		end

	// once raised, the memory request is held until memory acknowledges it
	assert property (@(posedge clk) disable iff (rst) (mem_req_i && !mem_ack_i) |=> mem_req_i)
		else begin
			$error("mem_req_o dropped before mem_ack_i rose");
			failures++;
		end

	// the memory side samples the command at any point while req is high
	assert property (@(posedge clk) disable iff (rst)
		mem_req_i |=> (!mem_req_i || $stable(mem_cmd_i)))
		else begin
			$error("mem_cmd_o changed while mem_req_o was high");
			failures++;
		end

	// ======================================================================
	// reset values
	// ======================================================================

	// while reset is held no handshake output and no array write may be active
	assert property (@(posedge clk) rst |-> (!cpu_ack_i && !mem_req_i && !wr_en_i))
		else begin
			$error("an output or array write enable was high during reset");
			failures++;
		end

endmodule

`default_nettype wire

//--- tb/dcache_tb.sv
// reads tb/dcache_tests.txt from the project root, and memory outside written lines holds {~adr, adr}
`timescale 1ns/1ns
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();

	logic     clk;
	logic     rst;
	logic     cpu_req;
	cpu_cmd_t cpu_cmd;
	logic     cpu_ack;
	line_t    cpu_rdata;
	logic     mem_req;
	mem_cmd_t mem_cmd;
	logic     mem_ack;
	line_t    mem_rdata;
	logic     snoop_v;
	addr_t    snoop_adr;
	logic     inv_all;

	// the test lines, held in queues so the run length is known up front
	logic [63:0] op_q [$];
	addr_t       adr_q [$];
	sel_t        sel_q [$];
	line_t       wdat_q [$];
	line_t       exp_q [$];
	int          lat_q [$];

	// lines written back or changed behind the cache's back
	line_t  mem_model [addr_t];
	integer seed = 32'h2c4b_8ba3;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic limit_set = 1'b0;

	dcache_top uut (
		.clk         (clk),
		.rst         (rst),
		.cpu_req_i   (cpu_req),
		.cpu_cmd_i   (cpu_cmd),
		.cpu_ack_o   (cpu_ack),
		.cpu_rdata_o (cpu_rdata),
		.mem_req_o   (mem_req),
		.mem_cmd_o   (mem_cmd),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata),
		.snoop_v_i   (snoop_v),
		.snoop_adr_i (snoop_adr),
		.inv_all_i   (inv_all)
	);

	bind dcache_top dcache_checker u_checker (
		.clk       (clk),
		.rst       (rst),
		.cpu_req_i (cpu_req_i),
		.cpu_ack_i (cpu_ack_o),
		.mem_req_i (mem_req_o),
		.mem_ack_i (mem_ack_i),
		.mem_cmd_i (mem_cmd_o),
		.wr_en_i   (array_wr.en)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// untouched memory gets a pattern built from every address bit
	function automatic line_t mem_read(input addr_t adr);
		if (mem_model.exists(adr)) begin
			return mem_model[adr];
		end
		return {~adr, adr};
	endfunction

	// one full four-phase CPU access, latency counted from the latching edge
	task automatic cpu_access(input logic we, input logic nc, input addr_t adr, input sel_t sel,
		input line_t wdat, input line_t expected, input logic chk_data, input int exp_lat);
		cpu_cmd_t cmd;
		int       edges;
		cmd.we  = we;
		cmd.nc  = nc;
		cmd.adr = adr;
		cmd.sel = sel;
		cmd.dat = wdat;
		edges   = 0;
		@(posedge clk);
		cpu_cmd <= cmd;
		cpu_req <= 1'b1;
		@(negedge clk);
		while (!cpu_ack) begin
			edges++;
			@(negedge clk);
		end
		// the first counted edge is the one where decode latches the command
		if (exp_lat != 0) begin
			check_value("cpu_ack_o latency", exp_lat, edges - 1);
		end
		if (chk_data) begin
			check_value("cpu_rdata_o", expected, cpu_rdata);
		end
		@(posedge clk);
		cpu_req <= 1'b0;
		@(negedge clk);
		while (cpu_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic snoop_pulse(input addr_t adr);
		@(posedge clk);
		snoop_adr <= adr;
		snoop_v   <= 1'b1;
		@(posedge clk);
		snoop_v   <= 1'b0;
	endtask

	task automatic inv_all_pulse();
		@(posedge clk);
		inv_all <= 1'b1;
		@(posedge clk);
		inv_all <= 1'b0;
	endtask

	// ======================================================================
	// memory model
	// ======================================================================

	// answers each request after 0 to 3 idle cycles and then follows the four phases
	initial begin : memory_model
		int delay;
		forever begin
			@(negedge clk);
			if (mem_req) begin
				delay = {$random(seed)} % 4;
				repeat (delay) @(posedge clk);
				@(posedge clk);
				if (mem_cmd.we) begin
					mem_model[mem_cmd.adr] = mem_cmd.dat;
				end else begin
					mem_rdata <= mem_read(mem_cmd.adr);
				end
				mem_ack <= 1'b1;
				@(negedge clk);
				while (mem_req) begin
					@(negedge clk);
				end
				@(posedge clk);
				mem_ack <= 1'b0;
			end
		end
	end

	// ======================================================================
	// watchdog
	// ======================================================================

	initial begin : watchdog
		while (!(limit_set && (cycle_count > cycle_limit))) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

	// ======================================================================
	// stimulus
	// ======================================================================

	initial begin : stimulus
		int             fd;
		int             n;
		reg [8*160-1:0] line_buf;
		logic [63:0]    op;
		addr_t          adr;
		sel_t           sel;
		line_t          wdat;
		line_t          expected;
		int             lat;
		cpu_req   = 1'b0;
		cpu_cmd   = '0;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		snoop_v   = 1'b0;
		snoop_adr = '0;
		inv_all   = 1'b0;
		rst       = 1'b1;
		fd = $fopen("tb/dcache_tests.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("could not open the test file tb/dcache_tests.txt");
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				op = '0;
				n  = $sscanf(line_buf, "%s %h %h %h %h %d", op, adr, sel, wdat, expected, lat);
				if ((n >= 1) && (op == "#")) begin
					// comment lines carry no test
				end else if (n == 6) begin
					op_q.push_back(op);
					adr_q.push_back(adr);
					sel_q.push_back(sel);
					wdat_q.push_back(wdat);
					exp_q.push_back(expected);
					lat_q.push_back(lat);
				end else if (n > 0) begin
					error_count++;
					$display("a line of the test file does not have six columns");
				end
			end
			$fclose(fd);
		end
		if ((fd != 0) && (op_q.size() == 0)) begin
			error_count++;
			$display("the test file holds no test lines");
		end
		// 200 cycles per test line plus some room for reset
		cycle_limit = 200 * op_q.size() + 20;
		limit_set   = 1'b1;

		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"R":  cpu_access(1'b0, 1'b0, adr_q[i], sel_q[i], wdat_q[i], exp_q[i], 1'b1, lat_q[i]);
				"W":  cpu_access(1'b1, 1'b0, adr_q[i], sel_q[i], wdat_q[i], exp_q[i], 1'b1, lat_q[i]);
				"NR": cpu_access(1'b0, 1'b1, adr_q[i], sel_q[i], wdat_q[i], exp_q[i], 1'b1, 0);
				"NW": cpu_access(1'b1, 1'b1, adr_q[i], sel_q[i], wdat_q[i], exp_q[i], 1'b0, 0);
				"SNOOP": snoop_pulse(adr_q[i]);
				"INVALL": inv_all_pulse();
				"BACKDOOR": mem_model[adr_q[i]] = wdat_q[i];
				default: begin
					error_count++;
					$display("unknown operation %0s in the test file", op_q[i]);
				end
			endcase
		end

		repeat (4) @(posedge clk);
		// failed handshake and reset assertions count as errors too
		error_count += uut.u_checker.failures;
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dcache_top.f
source/dcache_pkg.sv
source/dcache_req_decode.sv
source/dcache_ways.sv
source/dcache_resp_ctrl.sv
source/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

//--- tb/dcache_tests.txt
# op address sel write_data expected_read_data hit_latency, all hex except hit_latency
# hit_latency 4 demands a hit acked 4 cycles after the latching edge and 0 skips that check
R 00000208 00 0000000000000000 fffffdf700000208 0
R 00000208 00 0000000000000000 fffffdf700000208 4
W 00000208 0f 1122334455667788 fffffdf755667788 4
R 00000208 00 0000000000000000 fffffdf755667788 4
W 00000000 ff a0a0a0a000000001 a0a0a0a000000001 0
W 00000080 ff a1a1a1a100000002 a1a1a1a100000002 0
W 00000100 ff a2a2a2a200000003 a2a2a2a200000003 0
W 00000180 f0 b3b3b3b300000000 b3b3b3b300000180 0
R 00000000 00 0000000000000000 a0a0a0a000000001 0
R 00000080 00 0000000000000000 a1a1a1a100000002 0
R 00000100 00 0000000000000000 a2a2a2a200000003 0
R 00000180 00 0000000000000000 b3b3b3b300000180 0
R 00001010 00 0000000000000000 ffffefef00001010 0
NW 00003000 ff cafef00d12345678 0000000000000000 0
NR 00003000 00 0000000000000000 cafef00d12345678 0
R 00001010 00 0000000000000000 ffffefef00001010 4
R 00002018 00 0000000000000000 ffffdfe700002018 0
BACKDOOR 00002018 00 0badcafe00c0ffee 0000000000000000 0
SNOOP 00002018 00 0000000000000000 0000000000000000 0
R 00002018 00 0000000000000000 0badcafe00c0ffee 0
BACKDOOR 00001010 00 5555aaaa1234abcd 0000000000000000 0
INVALL 00000000 00 0000000000000000 0000000000000000 0
R 00001010 00 0000000000000000 5555aaaa1234abcd 0
R 00002018 00 0000000000000000 0badcafe00c0ffee 0
